// ==== sam_video_pkg.sv ====
package sam_video_pkg;

    ////////////////////////////////////////
    // Video geometry
    ////////////////////////////////////////

    // Input line length in 12 MHz pixels, also output line length in clk24 cycles
    localparam int H_TOTAL_IN = 384;
    // Wide enough to hold one past the last position
    localparam int POS_W = $clog2(H_TOTAL_IN + 1);
    localparam logic [POS_W-1:0] POS_LAST = POS_W'(H_TOTAL_IN - 1);
    // Idle marker, no line running
    localparam logic [POS_W-1:0] POS_IDLE = POS_W'(H_TOTAL_IN);

    // Output line shaping, in clk24 positions
    localparam logic [POS_W-1:0] HSYNC_OUT = POS_W'(46);
    localparam logic [POS_W-1:0] DE_START = POS_W'(64);
    localparam logic [POS_W-1:0] DE_LEN = POS_W'(256);

    ////////////////////////////////////////
    // SAM colour word
    ////////////////////////////////////////

    localparam int COLOUR_W = 7;
    localparam int IDX_W = 4;
    localparam int CLUT_N = 2 ** IDX_W;

    // Bit order G1 R1 B1 bright G0 R0 B0
    localparam int BIT_G1 = 6;
    localparam int BIT_R1 = 5;
    localparam int BIT_B1 = 4;
    localparam int BIT_BRIGHT = 3;
    localparam int BIT_G0 = 2;
    localparam int BIT_R0 = 1;
    localparam int BIT_B0 = 0;

    ////////////////////////////////////////
    // Register map and bus responses
    ////////////////////////////////////////

    // CLUT entry n at ADDR_CLUT_BASE + 4n
    localparam logic [7:0] ADDR_CLUT_BASE = 8'h00;
    // Control, bit 0 is scanline enable
    localparam logic [7:0] ADDR_CTRL = 8'h40;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== sam_video_if.sv ====
`timescale 1ns/1ps

////////////////////////////////////////
// CLUT lookup between regs and doubler
////////////////////////////////////////

interface clut_if;
    import sam_video_pkg::*;

    // Palette index of the pixel being captured
    logic [IDX_W-1:0]    index;
    // Looked-up SAM colour, combinational from the register array
    logic [COLOUR_W-1:0] colour;
    // Control register bit 0
    logic                scanline_en;

    // Register side answers the lookup
    modport regs (
        input  index,
        output colour,
        output scanline_en
    );

    // Doubler side asks with the index
    modport lookup (
        output index,
        input  colour
    );

endinterface

////////////////////////////////////////
// Doubled scan stream to output stage
////////////////////////////////////////

interface scan_if;
    import sam_video_pkg::*;

    // All four aligned, one position per clk24
    logic [COLOUR_W-1:0] colour;
    // Pulse with position 0 of each output line
    logic                line_start;
    // Second read of the stored line
    logic                second_copy;
    // Qualifies line_start, this output line sits in vertical sync
    logic                frame_start;

    modport src (
        output colour,
        output line_start,
        output second_copy,
        output frame_start
    );

    modport sink (
        input  colour,
        input  line_start,
        input  second_copy,
        input  frame_start
    );

endinterface

// ==== sam_reg_decode.sv ====
`timescale 1ns/1ps

module sam_reg_decode (
    input  logic        clk24,
    input  logic        rst,
    // AXI4-Lite write address
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    // AXI4-Lite write data
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    // AXI4-Lite write response
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    // AXI4-Lite read address
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    // AXI4-Lite read data
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Lookup port to the doubler
    clut_if.regs        clut
);
    import sam_video_pkg::*;

    // Palette store
    logic [COLOUR_W-1:0] clut_regs [CLUT_N];
    logic                scanline_en;

    logic                wr_go;
    logic                rd_go;
    logic [7:0]          wr_off;
    logic [7:0]          rd_off;
    logic                wr_clut_hit;
    logic                wr_ctrl_hit;
    logic                rd_clut_hit;
    logic                rd_ctrl_hit;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Offsets from the CLUT base, low two bits are byte lanes
    assign wr_off = awaddr - ADDR_CLUT_BASE;
    assign rd_off = araddr - ADDR_CLUT_BASE;

    // 16 words from the base
    assign wr_clut_hit = (wr_off[7:6] == 2'b00);
    assign rd_clut_hit = (rd_off[7:6] == 2'b00);
    assign wr_ctrl_hit = (awaddr[7:2] == ADDR_CTRL[7:2]);
    assign rd_ctrl_hit = (araddr[7:2] == ADDR_CTRL[7:2]);

    // Handshake cycles
    assign wr_go = awready && awvalid && wready && wvalid;
    assign rd_go = arready && arvalid;

    ////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////

    // AW and W accepted together, one cycle, only with no response pending
    always_ff @(posedge clk24) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_go) begin
                bvalid <= 1'b1;
                bresp  <= (wr_clut_hit || wr_ctrl_hit) ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Register updates land in the same edge that raises bvalid
    always_ff @(posedge clk24) begin
        if (wr_go && wstrb[0] && wr_clut_hit) begin
            clut_regs[wr_off[5:2]] <= wdata[COLOUR_W-1:0];
        end
    end

    always_ff @(posedge clk24) begin
        if (rst) begin
            scanline_en <= 1'b0;
        end else if (wr_go && wstrb[0] && wr_ctrl_hit) begin
            scanline_en <= wdata[0];
        end
    end

    ////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////

    // One read in flight, next waits for rready
    always_ff @(posedge clk24) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_go) begin
                rvalid <= 1'b1;
                rresp  <= (rd_clut_hit || rd_ctrl_hit) ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data, zero-extended
    always_ff @(posedge clk24) begin
        if (rd_go) begin
            if (rd_clut_hit) begin
                rdata <= {{(32 - COLOUR_W){1'b0}}, clut_regs[rd_off[5:2]]};
            end else if (rd_ctrl_hit) begin
                rdata <= {31'b0, scanline_en};
            end else begin
                rdata <= 32'b0;
            end
        end
    end

    // Lookup is pure combinational
    assign clut.colour      = clut_regs[clut.index];
    assign clut.scanline_en = scanline_en;

endmodule

// ==== line_doubler.sv ====
`timescale 1ns/1ps

module line_doubler (
    input  logic                            clk24,
    input  logic                            rst,
    // Video source side
    output logic                            pix_ce,
    input  logic [sam_video_pkg::IDX_W-1:0] pix_index,
    input  logic                            hsync_in_n,
    input  logic                            vsync_in_n,
    // CLUT lookup
    clut_if.lookup                          clut,
    // Doubled stream out
    scan_if.src                             scan
);
    import sam_video_pkg::*;

    // Input side
    logic                  hsync_prev;
    logic                  in_start;
    logic [POS_W-1:0]      wr_pos;
    logic [POS_W-1:0]      wr_addr;
    logic                  wr_half;
    logic                  wr_sel;
    logic                  have_line;
    logic                  v_state;

    // Readout side
    logic                  rd_half;
    logic [POS_W-1:0]      rd_pos;
    logic                  rd_second;
    logic                  out_first;
    logic                  out_second;
    logic                  out_start_q;

    // Two-line ping-pong store
    logic [COLOUR_W-1:0]   line_buf [2][H_TOTAL_IN];

    ////////////////////////////////////////
    // 12 MHz pixel enable
    ////////////////////////////////////////

    // Low right after reset, then every other cycle
    always_ff @(posedge clk24) begin
        if (rst) begin
            pix_ce <= 1'b0;
        end else begin
            pix_ce <= ~pix_ce;
        end
    end

    ////////////////////////////////////////
    // Input line timing
    ////////////////////////////////////////

    // Line begins on the first low hsync pixel
    assign in_start = pix_ce && !hsync_in_n && hsync_prev;

    // Pixel 0 goes into the freshly selected half
    assign wr_sel  = in_start ? ~wr_half : wr_half;
    assign wr_addr = in_start ? '0 : wr_pos;

    always_ff @(posedge clk24) begin
        if (rst) begin
            hsync_prev <= 1'b1;
            wr_pos     <= POS_IDLE;
            wr_half    <= 1'b0;
            rd_half    <= 1'b0;
            have_line  <= 1'b0;
            v_state    <= 1'b0;
        end else begin
            if (pix_ce) begin
                hsync_prev <= hsync_in_n;
            end
            if (in_start) begin
                // Swap halves, finished line becomes the read side
                wr_pos    <= POS_W'(1);
                wr_half   <= ~wr_half;
                rd_half   <= wr_half;
                have_line <= 1'b1;
                // Vertical state held for both output copies
                v_state   <= ~vsync_in_n;
            end else if (pix_ce && wr_pos != POS_IDLE) begin
                wr_pos <= wr_pos + 1'b1;
            end
        end
    end

    // Capture the looked-up colour, stops at line end
    assign clut.index = pix_index;

    always_ff @(posedge clk24) begin
        if (pix_ce && wr_addr != POS_IDLE) begin
            line_buf[wr_sel][wr_addr] <= clut.colour;
        end
    end

    ////////////////////////////////////////
    // Double-rate readout
    ////////////////////////////////////////

    // First copy on the input line start, once a full line is stored
    assign out_first = in_start && have_line;
    // Second copy H_TOTAL_IN cycles later
    assign out_second = !rd_second && (rd_pos == POS_LAST) && !out_first;

    always_ff @(posedge clk24) begin
        if (rst) begin
            rd_pos      <= POS_LAST;
            rd_second   <= 1'b1;
            out_start_q <= 1'b0;
        end else begin
            out_start_q <= out_first || out_second;
            if (out_first || out_second) begin
                rd_pos    <= '0;
                rd_second <= out_second;
            end else if (rd_pos != POS_LAST) begin
                rd_pos <= rd_pos + 1'b1;
            end
        end
    end

    // Flags line up with the registered buffer read
    always_ff @(posedge clk24) begin
        if (rst) begin
            scan.line_start  <= 1'b0;
            scan.frame_start <= 1'b0;
            scan.second_copy <= 1'b0;
        end else begin
            scan.line_start  <= out_start_q;
            scan.frame_start <= out_start_q && v_state;
            scan.second_copy <= rd_second;
        end
    end

    // Position p appears two cycles after the line start plus p
    always_ff @(posedge clk24) begin
        scan.colour <= line_buf[rd_half][rd_pos];
    end

endmodule

// ==== vga_output.sv ====
`timescale 1ns/1ps

module vga_output (
    input  logic       clk24,
    input  logic       rst,
    scan_if.sink       scan,
    input  logic       scanline_en,
    output logic [2:0] r,
    output logic [2:0] g,
    output logic [2:0] b,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);
    import sam_video_pkg::*;

    logic [POS_W-1:0] pos;
    logic [POS_W-1:0] nxt_pos;
    logic             nxt_de;
    logic             nxt_hsync;
    logic [8:0]       nxt_rgb;

    ////////////////////////////////////////
    // SAM colour to 3-bit RGB
    ////////////////////////////////////////

    // Each channel {hi, lo, bright}; dimmed halves hi/lo and drops bright
    function automatic logic [8:0] map_colour(input logic [COLOUR_W-1:0] c,
                                              input logic dim);
        logic [1:0] rc;
        logic [1:0] gc;
        logic [1:0] bc;
        logic       br;
        rc = {c[BIT_R1], c[BIT_R0]};
        gc = {c[BIT_G1], c[BIT_G0]};
        bc = {c[BIT_B1], c[BIT_B0]};
        br = c[BIT_BRIGHT];
        if (dim) begin
            rc = rc >> 1;
            gc = gc >> 1;
            bc = bc >> 1;
            br = 1'b0;
        end
        return {rc, br, gc, br, bc, br};
    endfunction

    ////////////////////////////////////////
    // Position counter
    ////////////////////////////////////////

    // Restart on line_start, park at POS_IDLE when no line follows
    always_comb begin
        if (scan.line_start) begin
            nxt_pos = '0;
        end else if (pos != POS_IDLE) begin
            nxt_pos = pos + 1'b1;
        end else begin
            nxt_pos = pos;
        end
    end

    // Idle position lies outside both windows
    assign nxt_hsync = (nxt_pos >= HSYNC_OUT);
    assign nxt_de    = (nxt_pos >= DE_START) && (nxt_pos < DE_START + DE_LEN);
    assign nxt_rgb   = nxt_de ? map_colour(scan.colour, scanline_en && scan.second_copy)
                              : 9'b0;

    // One register stage, hsync falls with the registered line start
    always_ff @(posedge clk24) begin
        if (rst) begin
            pos   <= POS_IDLE;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            r     <= 3'b0;
            g     <= 3'b0;
            b     <= 3'b0;
        end else begin
            pos   <= nxt_pos;
            hsync <= nxt_hsync;
            de    <= nxt_de;
            {r, g, b} <= nxt_rgb;
            // Vertical sync carried for the whole output line
            if (scan.line_start) begin
                vsync <= ~scan.frame_start;
            end
        end
    end

endmodule

// ==== sam_video_top.sv ====
`timescale 1ns/1ps

module sam_video_top (
    input  logic                            clk24,
    input  logic                            rst,
    // AXI4-Lite register bus
    input  logic [7:0]                      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [7:0]                      araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    // 12 MHz palette video in
    output logic                            pix_ce,
    input  logic [sam_video_pkg::IDX_W-1:0] pix_index,
    input  logic                            hsync_in_n,
    input  logic                            vsync_in_n,
    // VGA out
    output logic [2:0]                      r,
    output logic [2:0]                      g,
    output logic [2:0]                      b,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            de
);

    clut_if clut_bus ();
    scan_if scan_bus ();

    // Register file and palette
    sam_reg_decode i_reg_decode (
        .clk24   (clk24),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .clut    (clut_bus)
    );

    // Scan doubler
    line_doubler i_line_doubler (
        .clk24      (clk24),
        .rst        (rst),
        .pix_ce     (pix_ce),
        .pix_index  (pix_index),
        .hsync_in_n (hsync_in_n),
        .vsync_in_n (vsync_in_n),
        .clut       (clut_bus),
        .scan       (scan_bus)
    );

    // Sync shaping and RGB, scanline bit taken straight from the control reg
    vga_output i_vga_output (
        .clk24       (clk24),
        .rst         (rst),
        .scan        (scan_bus),
        .scanline_en (clut_bus.scanline_en),
        .r           (r),
        .g           (g),
        .b           (b),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de)
    );

endmodule

// ==== tb_sam_video.sv ====
`timescale 1ns/1ps

module tb_sam_video;
    import sam_video_pkg::*;

    localparam string DATA_FILE = "sam_video_input.txt";
    localparam logic [31:0] SEED_DEFAULT = 32'hc7f5f07a;
    // Input hsync pulse width in pixels
    localparam int HSYNC_IN_LEN = 32;
    // Bus handshake limit in cycles
    localparam int BUS_WAIT = 50;

    logic        clk24;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        pix_ce;
    logic [IDX_W-1:0] pix_index;
    logic        hsync_in_n;
    logic        vsync_in_n;
    logic [2:0]  r;
    logic [2:0]  g;
    logic [2:0]  b;
    logic        hsync;
    logic        vsync;
    logic        de;

    // Parsed records
    string       rec_kind[$];
    logic [31:0] rec_a[$];
    logic [31:0] rec_b[$];
    logic [31:0] rec_c[$];
    int          n_lines;
    longint      watch_ns;
    bit          parsed;

    // Reference model state
    logic [COLOUR_W-1:0] shadow_clut [CLUT_N];
    logic                shadow_ctrl;
    logic [COLOUR_W-1:0] cur_line [H_TOTAL_IN];
    logic [COLOUR_W-1:0] prev_line [H_TOTAL_IN];
    bit                  have_prev;
    logic [8:0]          exp_q[$];
    logic [8:0]          exp_pix;
    logic [31:0]         rng;
    int                  data_lines;
    int                  vs_low_lines;

    // Monitor counters
    logic hsync_q;
    logic ce_exp;
    int   hs_falls;
    int   hs_low;
    int   de_cycles;
    int   vs_out_lines;

    sam_video_top i_dut (.*);

    ////////////////////////////////////////
    // Clock, watchdog, helpers
    ////////////////////////////////////////

    initial begin
        clk24 = 1'b0;
        forever #10 clk24 = ~clk24;
    end

    // Every line at two clk24 per pixel plus margin
    initial begin
        wait (parsed);
        #(watch_ns);
        abort_run("timeout, the video output did not finish in time");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Channel is {hi, lo, bright}
    // Dimmed keeps hi in the middle bit only
    function automatic logic [8:0] expect_rgb(input logic [COLOUR_W-1:0] c, input logic dim);
        logic [2:0] rr;
        logic [2:0] gg;
        logic [2:0] bb;
        rr = {c[BIT_R1], c[BIT_R0], c[BIT_BRIGHT]};
        gg = {c[BIT_G1], c[BIT_G0], c[BIT_BRIGHT]};
        bb = {c[BIT_B1], c[BIT_B0], c[BIT_BRIGHT]};
        if (dim) begin
            rr = {1'b0, rr[2], 1'b0};
            gg = {1'b0, gg[2], 1'b0};
            bb = {1'b0, bb[2], 1'b0};
        end
        return {rr, gg, bb};
    endfunction

    ////////////////////////////////////////
    // AXI4-Lite master tasks
    ////////////////////////////////////////

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        int waited;
        waited = 0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clk24);
        while (!(awready && wready)) begin
            waited++;
            if (waited > BUS_WAIT) abort_run("write address and data were never accepted");
            @(negedge clk24);
        end
        @(posedge clk24);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk24);
        while (!bvalid) begin
            waited++;
            if (waited > BUS_WAIT) abort_run("write response never arrived");
            @(negedge clk24);
        end
        check($sformatf("bresp_%02h", addr), 32'(resp), 32'(bresp));
        // Shadow follows accepted writes only
        if (resp == RESP_OKAY) begin
            if (addr < ADDR_CLUT_BASE + 8'(4 * CLUT_N)) begin
                shadow_clut[addr[5:2]] = data[COLOUR_W-1:0];
            end else if (addr == ADDR_CTRL) begin
                shadow_ctrl = data[0];
            end
        end
        @(posedge clk24);
        #2;
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
        int waited;
        waited  = 0;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk24);
        while (!arready) begin
            waited++;
            if (waited > BUS_WAIT) abort_run("read address was never accepted");
            @(negedge clk24);
        end
        @(posedge clk24);
        #2;
        arvalid = 1'b0;
        @(negedge clk24);
        while (!rvalid) begin
            waited++;
            if (waited > BUS_WAIT) abort_run("read data never arrived");
            @(negedge clk24);
        end
        check($sformatf("rdata_%02h", addr), data, rdata);
        check($sformatf("rresp_%02h", addr), 32'(resp), 32'(rresp));
        @(posedge clk24);
        #2;
        rready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Video source and reference model
    ////////////////////////////////////////

    task automatic send_line(input int mode, input logic [31:0] seed, input logic vs,
                             input bit counted);
        logic [IDX_W-1:0] idx;
        int p;
        rng = (seed == 0) ? SEED_DEFAULT : seed;
        // Stored line shows twice from this start
        // Scanline bit as of now
        if (have_prev) begin
            for (p = DE_START; p < DE_START + DE_LEN; p++) begin
                exp_q.push_back(expect_rgb(prev_line[p], 1'b0));
            end
            for (p = DE_START; p < DE_START + DE_LEN; p++) begin
                exp_q.push_back(expect_rgb(prev_line[p], shadow_ctrl));
            end
            if (!vs) vs_low_lines += 2;
        end
        for (p = 0; p < H_TOTAL_IN; p++) begin
            if (mode == 0) begin
                rng = xorshift(rng);
                idx = rng[IDX_W-1:0];
            end else begin
                idx = IDX_W'(p);
            end
            cur_line[p] = shadow_clut[idx];
            // One pixel per enabled cycle
            while (!pix_ce) begin
                @(posedge clk24);
                #2;
            end
            pix_index  = idx;
            hsync_in_n = (p >= HSYNC_IN_LEN);
            vsync_in_n = vs;
            @(posedge clk24);
            #2;
        end
        prev_line = cur_line;
        have_prev = 1'b1;
        if (counted) data_lines++;
    endtask

    // Output side sampled mid-cycle
    always @(negedge clk24) begin
        if (!rst) begin
            // Pixel enable starts low and alternates every cycle
            check("pix_ce", 32'(ce_exp), 32'(pix_ce));
            ce_exp = ~ce_exp;
            if (hsync_q && !hsync) begin
                hs_falls++;
                if (!vsync) vs_out_lines++;
            end
            // Sync pulse width measured up to each rise
            if (!hsync) begin
                hs_low++;
            end else if (!hsync_q) begin
                check("hsync_width", 32'(HSYNC_OUT), 32'(hs_low));
                hs_low = 0;
            end
            hsync_q = hsync;
            if (de) begin
                de_cycles++;
                if (exp_q.size() == 0) abort_run("de went high with no line expected");
                exp_pix = exp_q.pop_front();
                check($sformatf("pixel_%0d", de_cycles), 32'(exp_pix), 32'({r, g, b}));
            end else begin
                check("rgb_blank", 32'(0), 32'({r, g, b}));
            end
            // Nothing shown before the first output line
            if (hs_falls == 0) begin
                check("idle_hsync", 32'(1), 32'(hsync));
                check("idle_vsync", 32'(1), 32'(vsync));
                check("idle_de", 32'(0), 32'(de));
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int fd;
        int code;
        int i;
        string kind;
        string junk;
        logic [31:0] fa;
        logic [31:0] fb;
        logic [31:0] fc;
        rst        = 1'b1;
        awaddr     = 8'h00;
        awvalid    = 1'b0;
        wdata      = 32'h0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = 8'h00;
        arvalid    = 1'b0;
        rready     = 1'b0;
        pix_index  = '0;
        hsync_in_n = 1'b1;
        vsync_in_n = 1'b1;
        hsync_q    = 1'b1;
        ce_exp     = 1'b0;
        shadow_ctrl = 1'b0;
        have_prev  = 1'b0;
        n_lines    = 0;
        data_lines = 0;
        vs_low_lines = 0;
        hs_falls   = 0;
        hs_low     = 0;
        de_cycles  = 0;
        vs_out_lines = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) abort_run("cannot open the stimulus file");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) break;
            if (kind == "#") begin
                code = $fgets(junk, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", fa, fb, fc);
                if (code != 3) abort_run("malformed record in the stimulus file");
                rec_kind.push_back(kind);
                rec_a.push_back(fa);
                rec_b.push_back(fb);
                rec_c.push_back(fc);
                if (kind == "l") n_lines++;
            end
        end
        $fclose(fd);
        // Data lines plus the closing line
        watch_ns = longint'(n_lines + 1) * 2 * H_TOTAL_IN * 20 + 10000;
        parsed = 1'b1;
        repeat (4) @(posedge clk24);
        #2;
        rst = 1'b0;
        @(negedge clk24);
        check("reset_bus", 32'(0), 32'({awready, wready, bvalid, arready, rvalid}));
        @(posedge clk24);
        #2;
        for (i = 0; i < rec_kind.size(); i++) begin
            if (rec_kind[i] == "w") begin
                bus_write(rec_a[i][7:0], rec_b[i], rec_c[i][1:0]);
            end else if (rec_kind[i] == "r") begin
                bus_read(rec_a[i][7:0], rec_b[i], rec_c[i][1:0]);
            end else if (rec_kind[i] == "l") begin
                send_line(int'(rec_a[i]), rec_b[i], rec_c[i][0], 1'b1);
            end else begin
                abort_run($sformatf("unknown record kind %s", rec_kind[i]));
            end
        end
        // Closing line pushes out the last stored one
        send_line(1, 32'h0, 1'b1, 1'b0);
        while (exp_q.size() != 0) @(posedge clk24);
        @(negedge clk24);
        check("hsync_falls", 32'(2 * data_lines), 32'(hs_falls));
        check("de_cycles", 32'(int'(DE_LEN) * 2 * data_lines), 32'(de_cycles));
        check("vsync_lines", 32'(vs_low_lines), 32'(vs_out_lines));
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sam_video_input.txt ====
# w address data expected_bresp    r address expected_rdata expected_rresp
# l fill_mode(0 xorshift, 1 ramp) seed(0 default) vsync_in_n    responses 0 OKAY 2 SLVERR
w 00 00000000 0
w 04 ffffff7f 0
w 08 00000012 0
w 0c 00000023 0
w 10 00000034 0
w 14 00000045 0
w 18 00000056 0
w 1c 00000067 0
w 20 00000078 0
w 24 00000009 0
w 28 0000001a 0
w 2c 0000002b 0
w 30 0000003c 0
w 34 0000004d 0
w 38 0000005e 0
w 3c 0000006f 0
r 00 00000000 0
r 04 0000007f 0
r 08 00000012 0
r 0c 00000023 0
r 10 00000034 0
r 14 00000045 0
r 18 00000056 0
r 1c 00000067 0
r 20 00000078 0
r 24 00000009 0
r 28 0000001a 0
r 2c 0000002b 0
r 30 0000003c 0
r 34 0000004d 0
r 38 0000005e 0
r 3c 0000006f 0
w 44 00000055 2
w 80 0000007f 2
r 44 00000000 2
r fc 00000000 2
r 04 0000007f 0
r 40 00000000 0
l 0 00000000 1
l 1 00000000 1
l 0 1234abcd 0
l 0 00000005 0
w 40 00000001 0
r 40 00000001 0
l 0 9e3779b9 1
l 1 00000000 1
w 0c 00000070 0
w 40 00000000 0
l 0 00000077 1
l 1 00000000 1

// ==== build.f ====
sam_video_pkg.sv
sam_video_if.sv
sam_reg_decode.sv
line_doubler.sv
vga_output.sv
sam_video_top.sv
tb_sam_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sam_video -f build.f \
    -o sim_sam_video > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_sam_video > sim.log 2>&1 || true
cat sim.log
! grep -q "TESTBENCH FAILED" sim.log && grep -q "TESTBENCH PASSED" sim.log
